/* fetch_assert.sv */
////////////////////////////////////////////////////////////////////////////
// Protocol assertions of the fetch unit, bound into fetch_top
// Memory bus request rules, read limit and the decode side hold rule
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_assert (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       instr_req_i,
  input  logic [fetch_pkg::XLEN-1:0] instr_addr_i,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  fetch_pkg::port_state_e     port_state_i,
  input  logic                       valid_i,
  input  logic                       ready_i,
  input  logic                       branch_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  input  logic [fetch_pkg::XLEN-1:0] addr_i
);

  int         fail_count = 0;  // Failed assertions so far
  logic [2:0] outstanding;     // Reads granted on the bus and not yet answered

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 3'd0;
    end else begin
      outstanding <= outstanding + {2'b00, instr_req_i & instr_gnt_i} - {2'b00, instr_rvalid_i};
    end
  end

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else begin
      $error("Memory request dropped or changed before its grant");
      fail_count++;
    end

  addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    instr_addr_i[1:0] == 2'b00)
    else begin
      $error("Memory address is not word aligned");
      fail_count++;
    end

  read_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= 3'(fetch_pkg::MAX_OUTSTANDING))
    else begin
      $error("More reads in flight than the bus allows");
      fail_count++;
    end

  // An idle port has nothing left on the bus
  idle_empty: assert property (@(posedge clk) disable iff (!rst_n)
    port_state_i == fetch_pkg::PORT_IDLE |-> outstanding == 3'd0)
    else begin
      $error("Port is idle while reads are still in flight");
      fail_count++;
    end

  out_held: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && !ready_i && !branch_i |=> valid_i && $stable(rdata_i) && $stable(addr_i))
    else begin
      $error("Decode output changed while stalled");
      fail_count++;
    end

  branch_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |=> !valid_i)
    else begin
      $error("Decode output valid in the cycle after a branch");
      fail_count++;
    end

endmodule

bind fetch_top fetch_assert i_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .instr_req_i    (instr_req_o),
  .instr_addr_i   (instr_addr_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .port_state_i   (i_port.state_q),
  .valid_i        (valid_o),
  .ready_i        (ready_i),
  .branch_i       (branch_i),
  .rdata_i        (rdata_o),
  .addr_i         (addr_o)
);

/* fetch_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Reference model of the fetch stream
// Follows the program counter through the image and compares each
// instruction handed to decode, the stall hold and the branch bubble
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       valid_i,
  input  logic                       ready_i,
  input  logic                       branch_i,
  input  logic [fetch_pkg::XLEN-1:0] branch_addr_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  input  logic [fetch_pkg::XLEN-1:0] addr_i,
  input  logic [15:0]                image_i [256],
  output int                         xfer_count_o,
  output int                         err_count_o
);

  logic [fetch_pkg::XLEN-1:0] pc;        // Model program counter
  logic [fetch_pkg::XLEN-1:0] exp_data;
  logic [fetch_pkg::XLEN-1:0] held_data, held_addr;
  logic [7:0]                 idx;
  logic [15:0]                hw_lo;
  logic                       after_branch;  // Last cycle carried a branch
  logic                       hold_pending;  // Last cycle was a stall with valid high
  int                         errs;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc           = fetch_pkg::RESET_ADDR;
      after_branch = 1'b0;
      hold_pending = 1'b0;
      xfer_count_o <= 0;
      err_count_o  <= 0;
    end else begin
      errs = 0;
      if (after_branch && valid_i) begin
        $display("CHECK FAILED at %0t: valid_o after a branch expected 0, got %b",
                 $time, valid_i);
        errs++;
      end
      if (hold_pending && !valid_i) begin
        $display("CHECK FAILED at %0t: valid_o during stall expected 1, got %b",
                 $time, valid_i);
        errs++;
      end
      if (hold_pending && valid_i && rdata_i !== held_data) begin
        $display("CHECK FAILED at %0t: rdata_o during stall expected %h, got %h",
                 $time, held_data, rdata_i);
        errs++;
      end
      if (hold_pending && valid_i && addr_i !== held_addr) begin
        $display("CHECK FAILED at %0t: addr_o during stall expected %h, got %h",
                 $time, held_addr, addr_i);
        errs++;
      end

      if (branch_i) begin
        pc = {branch_addr_i[fetch_pkg::XLEN-1:1], 1'b0};  // Same-cycle transfer is void
      end else if (valid_i && ready_i) begin
        idx   = pc[8:1];
        hw_lo = image_i[idx];
        if (hw_lo[1:0] != 2'b11) begin
          exp_data = {16'h0000, hw_lo};
        end else begin
          exp_data = {image_i[idx + 8'd1], hw_lo};  // Upper half may sit in the next word
        end
        if (addr_i !== pc) begin
          $display("CHECK FAILED at %0t: addr_o expected %h, got %h", $time, pc, addr_i);
          errs++;
        end
        if (rdata_i !== exp_data) begin
          $display("CHECK FAILED at %0t: rdata_o expected %h, got %h",
                   $time, exp_data, rdata_i);
          errs++;
        end
        pc = pc + ((hw_lo[1:0] != 2'b11) ? 32'd2 : 32'd4);
        xfer_count_o <= xfer_count_o + 1;
      end

      after_branch = branch_i;
      hold_pending = valid_i && !ready_i && !branch_i;
      held_data    = rdata_i;
      held_addr    = addr_i;
      err_count_o  <= err_count_o + errs;
    end
  end

endmodule

/* fetch_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared constants and types of the instruction fetch front end
// Modules refer to these by scoped names such as fetch_pkg::XLEN
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // Address and instruction data width
  localparam int XLEN = 32;

  // First fetch address once reset is released
  localparam logic [XLEN-1:0] RESET_ADDR = 32'h0000_0080;

  localparam int QUEUE_DEPTH     = 2;  // Words held between memory and aligner
  localparam int MAX_OUTSTANDING = 2;  // Reads the bus may have in flight at once

  // Memory port state
  typedef enum logic [1:0] {
    PORT_IDLE,         // No request on the bus
    PORT_WAIT_GNT,     // Request raised and held until granted
    PORT_WAIT_RVALID   // Nothing requested but reads still in flight
  } port_state_e;

  // How the instruction at the program counter is assembled
  //
  //   FMT_FULL_ALIGNED  [ hi  lo ] both halves from the head word
  //   FMT_C_LOW         [ --  lo ] low half of the head word
  //   FMT_C_REG         [ held   ] the halfword kept from the last word
  //   FMT_FULL_SPLIT    [ held   ] low part, head word low half on top
  typedef enum logic [1:0] {
    FMT_FULL_ALIGNED,
    FMT_C_LOW,
    FMT_C_REG,
    FMT_FULL_SPLIT
  } instr_fmt_e;

endpackage

/* fetch_top.sv */
////////////////////////////////////////////////////////////////////////////
// Top level of the instruction fetch front end
// Memory port, word queue and aligner between the memory bus and decode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // Decode side
  input  logic                       ready_i,
  input  logic                       branch_i,
  input  logic [fetch_pkg::XLEN-1:0] branch_addr_i,
  output logic                       valid_o,
  output logic [fetch_pkg::XLEN-1:0] rdata_o,
  output logic [fetch_pkg::XLEN-1:0] addr_o,

  // Instruction memory bus
  output logic                       instr_req_o,
  output logic [fetch_pkg::XLEN-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic [fetch_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                       instr_rvalid_i
);

  logic                       flush;
  logic [fetch_pkg::XLEN-1:0] next_word_addr;
  logic [1:0]                 free_slots;
  logic                       word_push;
  logic [fetch_pkg::XLEN-1:0] word_data, word_addr;
  logic                       head_valid, head_pop;
  logic [fetch_pkg::XLEN-1:0] head_data, head_addr;

  imem_port i_port (
    .clk, .rst_n,
    .flush_i          (flush),
    .next_word_addr_i (next_word_addr),
    .free_slots_i     (free_slots),
    .word_push_o      (word_push),
    .word_data_o      (word_data),
    .word_addr_o      (word_addr),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rdata_i, .instr_rvalid_i
  );

  fetch_word_queue i_queue (
    .clk, .rst_n,
    .flush_i      (flush),
    .push_i       (word_push),
    .push_data_i  (word_data),
    .push_addr_i  (word_addr),
    .free_slots_o (free_slots),
    .head_valid_o (head_valid),
    .head_data_o  (head_data),
    .head_addr_o  (head_addr),
    .pop_i        (head_pop)
  );

  instr_aligner i_aligner (
    .clk, .rst_n,
    .branch_i, .branch_addr_i, .ready_i,
    .valid_o, .rdata_o, .addr_o,
    .head_valid_i     (head_valid),
    .head_data_i      (head_data),
    .head_addr_i      (head_addr),
    .head_pop_o       (head_pop),
    .flush_o          (flush),
    .next_word_addr_o (next_word_addr)
  );

endmodule

/* fetch_word_queue.sv */
////////////////////////////////////////////////////////////////////////////
// Short FIFO of fetched words and their word addresses
// Sits between the memory port and the aligner and empties on a flush
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_word_queue (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush_i,

  input  logic                       push_i,
  input  logic [fetch_pkg::XLEN-1:0] push_data_i,
  input  logic [fetch_pkg::XLEN-1:0] push_addr_i,
  output logic [1:0]                 free_slots_o,

  output logic                       head_valid_o,
  output logic [fetch_pkg::XLEN-1:0] head_data_o,
  output logic [fetch_pkg::XLEN-1:0] head_addr_o,
  input  logic                       pop_i
);

  logic [fetch_pkg::XLEN-1:0] data_q [fetch_pkg::QUEUE_DEPTH];
  logic [fetch_pkg::XLEN-1:0] addr_q [fetch_pkg::QUEUE_DEPTH];

  logic [$clog2(fetch_pkg::QUEUE_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
  logic [1:0]                                count_q;
  logic                                      push_ok, pop_ok;

  // A full queue still takes a word when the head leaves in the same cycle
  assign push_ok = push_i && ((count_q != 2'(fetch_pkg::QUEUE_DEPTH)) || pop_i);
  assign pop_ok  = pop_i && (count_q != 2'd0);

  assign free_slots_o = 2'(fetch_pkg::QUEUE_DEPTH) - count_q;
  assign head_valid_o = (count_q != 2'd0);
  assign head_data_o  = data_q[rd_ptr_q];
  assign head_addr_o  = addr_q[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 2'd0;
    end else if (flush_i) begin  // Flush wins over a push in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 2'd0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;  // Power of two depth wraps by itself
      if (pop_ok) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + {1'b0, push_ok} - {1'b0, pop_ok};
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      data_q[wr_ptr_q] <= push_data_i;
      addr_q[wr_ptr_q] <= push_addr_i;
    end
  end

endmodule

/* filelist.f */
fetch_pkg.sv
imem_port.sv
fetch_word_queue.sv
instr_aligner.sv
fetch_top.sv
fetch_assert.sv
fetch_checker.sv
tb_fetch_top.sv

/* imem_port.sv */
////////////////////////////////////////////////////////////////////////////
// Memory bus master of the fetch unit
// Issues word reads on the req/gnt/rvalid bus, keeps count of reads in
// flight and drops the responses of reads that were made before a flush
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module imem_port (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       flush_i,           // Restart at next_word_addr_i
  input  logic [fetch_pkg::XLEN-1:0] next_word_addr_i,
  input  logic [1:0]                 free_slots_i,      // Free queue entries

  output logic                       word_push_o,
  output logic [fetch_pkg::XLEN-1:0] word_data_o,
  output logic [fetch_pkg::XLEN-1:0] word_addr_o,

  output logic                       instr_req_o,
  output logic [fetch_pkg::XLEN-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic [fetch_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                       instr_rvalid_i
);

  fetch_pkg::port_state_e state_q, state_d;

  logic [fetch_pkg::XLEN-1:0] fetch_addr_q;   // Next word to request
  logic [fetch_pkg::XLEN-1:0] req_addr_q;     // Address of the request on the bus
  logic [1:0]                 inflight_q, inflight_d;  // Granted reads not yet answered
  logic [1:0]                 discard_q, discard_d;    // Of those, the ones to drop
  logic [1:0]                 live;
  logic                       drop_q, drop_d;  // Pending request is stale
  logic                       gnt_ok;
  logic                       rvalid_drop;
  logic                       can_issue;
  logic                       raise;

  // Request addresses in grant order, read back as the responses come in
  logic [fetch_pkg::XLEN-1:0] addr_rec_q [fetch_pkg::MAX_OUTSTANDING];
  logic                       wr_ptr_q, rd_ptr_q;

  assign instr_req_o  = (state_q == fetch_pkg::PORT_WAIT_GNT);
  assign instr_addr_o = req_addr_q;

  assign gnt_ok      = instr_req_o & instr_gnt_i;
  assign rvalid_drop = instr_rvalid_i & (discard_q != 2'd0);
  assign word_push_o = instr_rvalid_i & (discard_q == 2'd0);
  assign word_data_o = instr_rdata_i;
  assign word_addr_o = addr_rec_q[rd_ptr_q];

  // Live reads each claim a queue slot, so only ask for what the queue can take
  assign live       = inflight_q - discard_q;
  assign can_issue  = (flush_i || (live < free_slots_i)) &&
                      (inflight_q < 2'(fetch_pkg::MAX_OUTSTANDING));
  assign inflight_d = inflight_q + {1'b0, gnt_ok} - {1'b0, instr_rvalid_i};

  always_comb begin
    state_d = state_q;
    raise   = 1'b0;
    unique case (state_q)
      fetch_pkg::PORT_IDLE: begin
        if (can_issue) begin
          state_d = fetch_pkg::PORT_WAIT_GNT;
          raise   = 1'b1;
        end
      end
      fetch_pkg::PORT_WAIT_GNT: begin
        if (instr_gnt_i) state_d = fetch_pkg::PORT_WAIT_RVALID;  // Never drop a raised request
      end
      fetch_pkg::PORT_WAIT_RVALID: begin
        if (can_issue) begin  // Second read while the first is still out
          state_d = fetch_pkg::PORT_WAIT_GNT;
          raise   = 1'b1;
        end else if (inflight_d == 2'd0) begin
          state_d = fetch_pkg::PORT_IDLE;
        end
      end
      default: state_d = fetch_pkg::PORT_IDLE;
    endcase
  end

  // On a flush every read still out turns stale, and so does an ungranted request
  always_comb begin
    if (flush_i) begin
      discard_d = inflight_d;
      drop_d    = instr_req_o & ~instr_gnt_i;
    end else begin
      discard_d = discard_q - {1'b0, rvalid_drop} + {1'b0, gnt_ok & drop_q};
      drop_d    = drop_q & ~gnt_ok;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= fetch_pkg::PORT_IDLE;
      inflight_q   <= 2'd0;
      discard_q    <= 2'd0;
      drop_q       <= 1'b0;
      fetch_addr_q <= '0;  // Loaded by the flush the aligner raises after reset
      req_addr_q   <= '0;
      wr_ptr_q     <= 1'b0;
      rd_ptr_q     <= 1'b0;
    end else begin
      state_q    <= state_d;
      inflight_q <= inflight_d;
      discard_q  <= discard_d;
      drop_q     <= drop_d;
      if (flush_i) begin
        fetch_addr_q <= next_word_addr_i;
      end else if (gnt_ok && !drop_q) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;  // Step only past words that count
      end
      if (raise) req_addr_q <= flush_i ? next_word_addr_i : fetch_addr_q;
      if (gnt_ok) wr_ptr_q <= ~wr_ptr_q;
      if (instr_rvalid_i) rd_ptr_q <= ~rd_ptr_q;
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_ok) addr_rec_q[wr_ptr_q] <= req_addr_q;  // Tag for the matching response
  end

endmodule

/* instr_aligner.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction aligner of the fetch unit
// Keeps the program counter and one leftover halfword, builds 16-bit and
// 32-bit instructions from the queued words and hands them to decode
// through a registered valid/ready stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_aligner (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       branch_i,
  input  logic [fetch_pkg::XLEN-1:0] branch_addr_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output logic [fetch_pkg::XLEN-1:0] rdata_o,
  output logic [fetch_pkg::XLEN-1:0] addr_o,

  input  logic                       head_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] head_data_i,
  input  logic [fetch_pkg::XLEN-1:0] head_addr_i,
  output logic                       head_pop_o,

  output logic                       flush_o,
  output logic [fetch_pkg::XLEN-1:0] next_word_addr_o
);

  logic [fetch_pkg::XLEN-1:0] pc_q;        // Address of the next instruction to build
  logic [15:0]                hw_q;        // Upper half of a word already popped
  logic                       hw_valid_q;
  logic                       valid_q;
  logic [fetch_pkg::XLEN-1:0] rdata_q, addr_q;
  logic                       flush_q;

  fetch_pkg::instr_fmt_e      fmt;
  logic [fetch_pkg::XLEN-1:0] instr;
  logic [fetch_pkg::XLEN-1:0] pc_step;
  logic                       flushing;
  logic                       out_free;
  logic                       skip;
  logic                       uses_head;
  logic                       addr_ok;
  logic                       head_match;
  logic                       can_present;
  logic                       take;
  logic                       skip_pop;
  logic                       drop;

  assign valid_o          = valid_q;
  assign rdata_o          = rdata_q;
  assign addr_o           = addr_q;
  assign flush_o          = flush_q;
  assign next_word_addr_o = {pc_q[fetch_pkg::XLEN-1:2], 2'b00};

  ////////////////////////////////////////////////////////////////////////////
  // Instruction assembly
  ////////////////////////////////////////////////////////////////////////////

  // Neither the branch cycle nor the flush cycle after it may touch the queue
  assign flushing = branch_i | flush_q;
  assign out_free = !valid_q || ready_i;  // Output stage empty or emptying now
  assign skip     = !hw_valid_q && pc_q[1];  // Odd target with nothing held

  // With a halfword held, the head must be the word after the one at pc
  assign addr_ok    = (head_addr_i[fetch_pkg::XLEN-1:2] ==
                       pc_q[fetch_pkg::XLEN-1:2] + {{(fetch_pkg::XLEN-3){1'b0}}, hw_valid_q});
  assign head_match = head_valid_i && addr_ok;

  always_comb begin
    fmt = fetch_pkg::FMT_FULL_ALIGNED;
    if (hw_valid_q) begin
      fmt = (hw_q[1:0] != 2'b11) ? fetch_pkg::FMT_C_REG : fetch_pkg::FMT_FULL_SPLIT;
    end else if (head_data_i[1:0] != 2'b11) begin
      fmt = fetch_pkg::FMT_C_LOW;
    end
  end

  // Compressed instructions leave with zero upper bits
  always_comb begin
    unique case (fmt)
      fetch_pkg::FMT_C_LOW: begin
        instr   = {16'h0000, head_data_i[15:0]};
        pc_step = 32'd2;
      end
      fetch_pkg::FMT_C_REG: begin
        instr   = {16'h0000, hw_q};
        pc_step = 32'd2;
      end
      fetch_pkg::FMT_FULL_SPLIT: begin
        instr   = {head_data_i[15:0], hw_q};
        pc_step = 32'd4;
      end
      default: begin
        instr   = head_data_i;
        pc_step = 32'd4;
      end
    endcase
  end

  assign uses_head   = (fmt != fetch_pkg::FMT_C_REG);
  assign can_present = !skip && (!uses_head || head_match);
  assign take        = !flushing && out_free && can_present;
  assign skip_pop    = !flushing && skip && head_match;  // Keep only the upper half
  assign drop        = !flushing && head_valid_i && !addr_ok;  // Word from a stale stream

  assign head_pop_o = (take && uses_head) || skip_pop || drop;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q       <= fetch_pkg::RESET_ADDR;
      hw_valid_q <= 1'b0;
      valid_q    <= 1'b0;
      flush_q    <= 1'b1;  // Start-up flush hands the reset address to the port
    end else if (branch_i) begin
      pc_q       <= {branch_addr_i[fetch_pkg::XLEN-1:1], 1'b0};
      hw_valid_q <= 1'b0;
      valid_q    <= 1'b0;  // Branch beats a transfer in the same cycle
      flush_q    <= 1'b1;
    end else begin
      flush_q <= 1'b0;
      if (take) begin
        valid_q <= 1'b1;
        pc_q    <= pc_q + pc_step;
        unique case (fmt)
          fetch_pkg::FMT_C_LOW:      hw_valid_q <= 1'b1;  // Upper half waits its turn
          fetch_pkg::FMT_C_REG:      hw_valid_q <= 1'b0;
          fetch_pkg::FMT_FULL_SPLIT: hw_valid_q <= 1'b1;  // Head upper half replaces it
          default:                   hw_valid_q <= hw_valid_q;
        endcase
      end else if (ready_i) begin
        valid_q <= 1'b0;  // Transfer done and nothing to follow yet
      end
      if (skip_pop) hw_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rdata_q <= instr;
      addr_q  <= pc_q;
    end
    if ((take && uses_head) || skip_pop) hw_q <= head_data_i[31:16];
  end

endmodule

/* tb_fetch_top.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench of the instruction fetch front end
// Builds a random program of mixed 16-bit and 32-bit instructions, answers
// the memory bus with random delays and drives decode with random stalls
// and branches, while fetch_checker compares every delivered instruction
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_fetch_top;

  localparam int NUM_XFERS       = 400;  // Instructions to deliver before the run ends
  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 4;
  localparam int CYCLES_PER_XFER = 12;   // Worst case budget per delivered instruction
  localparam int NUM_BRANCHES    = 8;
  localparam int BRANCH_SPACING  = 45;   // Transfers between two branch pulses
  localparam int WATCHDOG_NS     = (NUM_XFERS * CYCLES_PER_XFER + RESET_CYCLES) * CLK_PERIOD;

  logic                       clk;
  logic                       rst_n;
  logic                       ready_i;
  logic                       branch_i;
  logic [fetch_pkg::XLEN-1:0] branch_addr_i;
  logic                       valid_o;
  logic [fetch_pkg::XLEN-1:0] rdata_o;
  logic [fetch_pkg::XLEN-1:0] addr_o;
  logic                       instr_req_o;
  logic [fetch_pkg::XLEN-1:0] instr_addr_o;
  logic                       instr_gnt_i;
  logic [fetch_pkg::XLEN-1:0] instr_rdata_i;
  logic                       instr_rvalid_i;

  logic [15:0] image [256];  // Program image, indexed by halfword and wrapping
  int          seed;
  int          cyc;           // Rising edges since reset was released
  int          gnt_wait;      // Cycles of request left before the grant
  int          due;
  int          last_due;      // Cycle of the last scheduled response
  int          branch_count;
  int          xfer_count;
  int          err_count;
  int          total_errors;
  logic [31:0] rnd;

  // Granted reads waiting for their response, oldest first
  logic [fetch_pkg::XLEN-1:0] rsp_addr_q [$];
  int                         rsp_due_q [$];

  fetch_top i_dut (
    .clk, .rst_n,
    .ready_i, .branch_i, .branch_addr_i,
    .valid_o, .rdata_o, .addr_o,
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rdata_i, .instr_rvalid_i
  );

  fetch_checker i_checker (
    .clk, .rst_n,
    .valid_i       (valid_o),
    .ready_i, .branch_i, .branch_addr_i,
    .rdata_i       (rdata_o),
    .addr_i        (addr_o),
    .image_i       (image),
    .xfer_count_o  (xfer_count),
    .err_count_o   (err_count)
  );

  // The memory holds the image repeated over the whole address space
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [7:0] idx;
    idx = addr[8:1];
    return {image[idx + 8'd1], image[idx]};
  endfunction

  // About half the halfwords start a compressed instruction
  task automatic build_image();
    logic [31:0] hw;
    for (int i = 0; i < 256; i++) begin
      hw = $random(seed);
      if (($random(seed) & 1) != 0) hw[1:0] = 2'b11;
      else if (hw[1:0] == 2'b11) hw[1:0] = 2'b01;
      image[i] = hw[15:0];
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory responder and decode side stimulus
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      cyc = cyc + 1;
      if (instr_req_o && instr_gnt_i) begin  // Grant in the cycle just ended
        due = cyc + (($random(seed) & 32'h7fff_ffff) % 3);  // Response 1 to 3 cycles later
        if (due <= last_due) due = last_due + 1;  // In order, one per cycle
        last_due = due;
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(due);
        gnt_wait = ($random(seed) & 32'h7fff_ffff) % 3;  // Delay for the next request
      end else if (instr_req_o && gnt_wait > 0) begin
        gnt_wait = gnt_wait - 1;
      end
      instr_gnt_i <= (gnt_wait == 0);  // Grant may already wait for the request

      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= read_word(rsp_addr_q[0]);
        void'(rsp_addr_q.pop_front());
        void'(rsp_due_q.pop_front());
      end else begin
        instr_rvalid_i <= 1'b0;
        instr_rdata_i  <= '0;
      end

      rnd = $random(seed);
      ready_i <= ((rnd & 32'h7fff_ffff) % 100) >= 30;  // Stall about 30 percent of cycles

      // Branches are spread over the run and target any halfword of the image
      if (branch_i) begin
        branch_i <= 1'b0;
      end else if (branch_count < NUM_BRANCHES &&
                   xfer_count >= (branch_count + 1) * BRANCH_SPACING &&
                   ($random(seed) & 3) == 0) begin
        rnd = $random(seed);
        branch_i      <= 1'b1;
        branch_addr_i <= fetch_pkg::RESET_ADDR + {rnd[7:0], 1'b0};
        branch_count  = branch_count + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 41;
    cyc            = 0;
    gnt_wait       = 0;
    last_due       = 0;
    branch_count   = 0;
    rst_n          = 1'b0;
    ready_i        = 1'b0;
    branch_i       = 1'b0;
    branch_addr_i  = '0;
    instr_gnt_i    = 1'b0;
    instr_rdata_i  = '0;
    instr_rvalid_i = 1'b0;
    build_image();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    wait (xfer_count >= NUM_XFERS);
    @(posedge clk);
    #1;
    total_errors = err_count + i_dut.i_assert.fail_count;
    $display("Run finished: %0d transfers, %0d checker errors, %0d assertion errors",
             xfer_count, err_count, i_dut.i_assert.fail_count);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Ends a run whose instructions stop arriving
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: only %0d of %0d instructions reached decode in time",
             xfer_count, NUM_XFERS);
    $display("Test FAILED");
    $finish;
  end

endmodule
